/* hw/fetch_pkg.sv */
// Fetch subsystem package
// Shared address, instruction and handshake types of the fetch path

`default_nettype none

package fetch_pkg;

  // Widths with a meaning
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [23:0] mtvec_t;
  typedef logic [4:0]  irq_id_t;

  // Redirect source selected by the controller
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_IRQ       = 3'd4,
    PC_MRET      = 3'd5
  } pc_mux_e;

  // Controller to fetch
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    irq_id_t irq_id;
    logic    halt_if;
  } fetch_ctrl_t;

  // Accepted redirect, seen by the FIFO and the IF/ID stage in the same cycle
  typedef struct packed {
    logic  set;
    addr_t target;
  } fetch_redirect_t;

  // One prefetch FIFO entry
  typedef struct packed {
    instr_t instr;
    logic   err;
  } fetch_resp_t;

  // IF/ID pipeline register towards decode
  typedef struct packed {
    logic   instr_valid;
    instr_t instr;
    addr_t  pc;
    logic   bus_err;
  } if_id_pipe_t;

endpackage

`default_nettype wire

/* hw/fetch_addr_gen.sv */
// Fetch address generator
// Picks the redirect target and issues word requests to instruction memory

`timescale 1ns/1ps
`default_nettype none

module fetch_addr_gen
(
  input  wire logic                       clk,
  input  wire logic                       rst_n,

  // Controller
  input  wire fetch_pkg::fetch_ctrl_t     ctrl_i,

  // Redirect target sources
  input  wire fetch_pkg::addr_t           boot_addr_i,
  input  wire fetch_pkg::mtvec_t          mtvec_i,
  input  wire fetch_pkg::addr_t           jump_target_i,
  input  wire fetch_pkg::addr_t           branch_target_i,
  input  wire fetch_pkg::addr_t           mepc_i,

  // Room left in the prefetch FIFO
  input  wire logic                       credit_i,

  // Memory request side
  output      logic                       instr_req_o,
  output      fetch_pkg::addr_t           instr_addr_o,
  input  wire logic                       instr_gnt_i,

  // To FIFO and IF/ID stage
  output      logic                       issue_o,
  output      fetch_pkg::fetch_redirect_t redirect_o
);

  typedef enum logic {
    IDLE,
    FETCH
  } state_e;

  state_e           state_q;
  fetch_pkg::addr_t target;
  fetch_pkg::addr_t fetch_addr_q;

  //////////////////////////////////////////////////////////////////////
  // Redirect target
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // Boot is the fallback
    target = {boot_addr_i[31:2], 2'b00};
    unique case (ctrl_i.pc_mux)
      fetch_pkg::PC_BOOT:      target = {boot_addr_i[31:2], 2'b00};
      fetch_pkg::PC_JUMP:      target = {jump_target_i[31:1], 1'b0};
      fetch_pkg::PC_BRANCH:    target = {branch_target_i[31:1], 1'b0};
      // All exceptions share the base address
      fetch_pkg::PC_EXCEPTION: target = {mtvec_i, 8'h00};
      // Vectored, base plus cause times 4
      fetch_pkg::PC_IRQ:       target = {mtvec_i, 1'b0, ctrl_i.irq_id, 2'b00};
      fetch_pkg::PC_MRET:      target = {mepc_i[31:1], 1'b0};
      default:                 target = {boot_addr_i[31:2], 2'b00};
    endcase
  end

  // Redirect is taken at the same edge the controller asserts it
  assign redirect_o.set    = ctrl_i.pc_set;
  assign redirect_o.target = target;

  //////////////////////////////////////////////////////////////////////
  // Fetch state and address
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q      <= IDLE;
      fetch_addr_q <= '0;
    end
    else
    begin
      if (ctrl_i.pc_set)
      begin
        // New stream, overrides a grant in the same cycle
        state_q      <= FETCH;
        fetch_addr_q <= target;
      end
      else if (issue_o)
      begin
        fetch_addr_q <= fetch_addr_q + 32'd4;
      end
    end
  end

  // Credit only changes on an issue, so a pending req is never withdrawn
  assign instr_req_o  = (state_q == FETCH) && credit_i;
  assign instr_addr_o = fetch_addr_q;
  assign issue_o      = instr_req_o && instr_gnt_i;

endmodule

`default_nettype wire

/* hw/prefetch_fifo.sv */
// Prefetch FIFO
// Buffers memory responses, tracks credit and drops stale ones after a flush

`timescale 1ns/1ps
`default_nettype none

module prefetch_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,

  input  wire fetch_pkg::fetch_redirect_t redirect_i,
  input  wire logic                       issue_i,

  // Memory response side
  input  wire logic                       rvalid_i,
  input  wire fetch_pkg::instr_t          rdata_i,
  input  wire logic                       err_i,

  output      logic                       credit_o,

  // Towards IF/ID stage
  output      logic                       valid_o,
  output      fetch_pkg::fetch_resp_t     resp_o,
  input  wire logic                       ready_i,

  output      logic                       busy_o
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = PTR_W + 1;

  typedef logic [CNT_W-1:0] cnt_t;

  fetch_pkg::fetch_resp_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  cnt_t                   count_q;
  cnt_t                   outst_q;
  cnt_t                   outst_n;
  cnt_t                   discard_q;
  logic [CNT_W:0]         used;
  logic                   wr_en;
  logic                   rd_en;

  // Stale responses never reach the buffer
  assign wr_en   = rvalid_i && (discard_q == '0);
  assign rd_en   = valid_o && ready_i;
  assign outst_n = outst_q + cnt_t'(issue_i) - cnt_t'(rvalid_i);

  // In-flight requests reserve their slot up front
  assign used     = {1'b0, outst_q} + {1'b0, count_q};
  assign credit_o = used < (CNT_W+1)'(FIFO_DEPTH);

  //////////////////////////////////////////////////////////////////////
  // Counters and pointers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      outst_q   <= '0;
      discard_q <= '0;
    end
    else
    begin
      outst_q <= outst_n;
      if (redirect_i.set)
      begin
        // Whatever is still in flight belongs to the old stream
        discard_q <= outst_n;
        wr_ptr_q  <= '0;
        rd_ptr_q  <= '0;
        count_q   <= '0;
      end
      else
      begin
        if (rvalid_i && (discard_q != '0))
          discard_q <= discard_q - cnt_t'(1);
        if (wr_en)
          wr_ptr_q <= wr_ptr_q + PTR_W'(1);
        if (rd_en)
          rd_ptr_q <= rd_ptr_q + PTR_W'(1);
        count_q <= count_q + cnt_t'(wr_en) - cnt_t'(rd_en);
      end
    end
  end

  // Storage
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr_q] <= '{instr: rdata_i, err: err_i};
  end

  assign valid_o = (count_q != '0);
  assign resp_o  = mem[rd_ptr_q];
  assign busy_o  = (outst_q != '0) || (count_q != '0);

endmodule

`default_nettype wire

/* hw/if_id_stage.sv */
// IF/ID register stage
// Tracks the PC of each instruction and hands one at a time to decode

`timescale 1ns/1ps
`default_nettype none

module if_id_stage
(
  input  wire logic                       clk,
  input  wire logic                       rst_n,

  input  wire fetch_pkg::fetch_redirect_t redirect_i,
  input  wire logic                       halt_i,

  // From prefetch FIFO
  input  wire logic                       valid_i,
  input  wire fetch_pkg::fetch_resp_t     resp_i,
  output      logic                       ready_o,

  // Decode side
  input  wire logic                       id_ready_i,
  output      fetch_pkg::if_id_pipe_t     if_id_pipe_o
);

  fetch_pkg::addr_t  pc_q;
  logic              instr_valid_q;
  fetch_pkg::instr_t instr_q;
  fetch_pkg::addr_t  instr_pc_q;
  logic              bus_err_q;
  logic              xfer;

  // Halt keeps new instructions out of ID
  assign ready_o = id_ready_i && !halt_i;
  assign xfer    = valid_i && ready_o;

  // PC and valid bit
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      pc_q          <= '0;
      instr_valid_q <= 1'b0;
    end
    else if (redirect_i.set)
    begin
      pc_q          <= redirect_i.target;
      instr_valid_q <= 1'b0;
    end
    else if (xfer)
    begin
      pc_q          <= pc_q + 32'd4;
      instr_valid_q <= 1'b1;
    end
    else if (id_ready_i)
    begin
      // ID took the last one and nothing new came in
      instr_valid_q <= 1'b0;
    end
  end

  // Payload, frozen while ID stalls
  always_ff @(posedge clk)
  begin
    if (xfer)
    begin
      instr_q    <= resp_i.instr;
      bus_err_q  <= resp_i.err;
      instr_pc_q <= pc_q;
    end
  end

  assign if_id_pipe_o = '{instr_valid: instr_valid_q, instr: instr_q,
                          pc: instr_pc_q, bus_err: bus_err_q};

endmodule

`default_nettype wire

/* hw/if_stage.sv */
// Instruction fetch stage top
// Address generator, prefetch FIFO and IF/ID register in a chain

`timescale 1ns/1ps
`default_nettype none

module if_stage #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n,

  // Controller
  input  wire fetch_pkg::fetch_ctrl_t ctrl_i,

  // Target sources
  input  wire fetch_pkg::addr_t       boot_addr_i,
  input  wire fetch_pkg::mtvec_t      mtvec_i,
  input  wire fetch_pkg::addr_t       jump_target_i,
  input  wire fetch_pkg::addr_t       branch_target_i,
  input  wire fetch_pkg::addr_t       mepc_i,

  // Instruction memory
  output      logic                   instr_req_o,
  output      fetch_pkg::addr_t       instr_addr_o,
  input  wire logic                   instr_gnt_i,
  input  wire logic                   instr_rvalid_i,
  input  wire fetch_pkg::instr_t      instr_rdata_i,
  input  wire logic                   instr_err_i,

  // Decode side
  input  wire logic                   id_ready_i,
  output      fetch_pkg::if_id_pipe_t if_id_pipe_o,
  output      logic                   if_busy_o
);

  fetch_pkg::fetch_redirect_t redirect;
  fetch_pkg::fetch_resp_t     fifo_resp;
  logic                       issue;
  logic                       credit;
  logic                       fifo_valid;
  logic                       fifo_ready;

  //////////////////////////////////////////////////////////////////////
  // Producer
  //////////////////////////////////////////////////////////////////////

  fetch_addr_gen fetch_addr_gen_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_i          (ctrl_i),
    .boot_addr_i     (boot_addr_i),
    .mtvec_i         (mtvec_i),
    .jump_target_i   (jump_target_i),
    .branch_target_i (branch_target_i),
    .mepc_i          (mepc_i),
    .credit_i        (credit),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .issue_o         (issue),
    .redirect_o      (redirect)
  );

  // Buffer
  prefetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) prefetch_fifo_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect_i (redirect),
    .issue_i    (issue),
    .rvalid_i   (instr_rvalid_i),
    .rdata_i    (instr_rdata_i),
    .err_i      (instr_err_i),
    .credit_o   (credit),
    .valid_o    (fifo_valid),
    .resp_o     (fifo_resp),
    .ready_i    (fifo_ready),
    .busy_o     (if_busy_o)
  );

  // Consumer
  if_id_stage if_id_stage_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect_i   (redirect),
    .halt_i       (ctrl_i.halt_if),
    .valid_i      (fifo_valid),
    .resp_i       (fifo_resp),
    .ready_o      (fifo_ready),
    .id_ready_i   (id_ready_i),
    .if_id_pipe_o (if_id_pipe_o)
  );

endmodule

`default_nettype wire

/* verification/if_stage_checker.sv */
// IF stage protocol checker
// Assertions on the memory port and the prefetch FIFO fill level

`timescale 1ns/1ps
`default_nettype none

module if_stage_checker #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire fetch_pkg::fetch_ctrl_t        ctrl_i,
  input  wire logic                          instr_req_i,
  input  wire fetch_pkg::addr_t              instr_addr_i,
  input  wire logic                          instr_gnt_i,
  input  wire logic                          instr_rvalid_i,
  input  wire logic [$clog2(FIFO_DEPTH):0]   fifo_count_i
);

  int unsigned outst_q;
  int unsigned assert_errs = 0;

  // Requests granted and not yet answered
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      outst_q <= 0;
    else
      outst_q <= outst_q + (instr_req_i && instr_gnt_i) - instr_rvalid_i;
  end

  // Pending request keeps its address unless redirected
  addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_i && !instr_gnt_i && !ctrl_i.pc_set) |=> (instr_req_i && $stable(instr_addr_i)))
    else
    begin
      $error("instr_addr changed or req dropped before the grant");
      assert_errs++;
    end

  req_in_reset: assert property (@(posedge clk) !rst_n |-> !instr_req_i)
    else
    begin
      $error("instr_req high during reset");
      assert_errs++;
    end

  rvalid_outst: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> (outst_q != 0))
    else
    begin
      $error("instr_rvalid with no request outstanding");
      assert_errs++;
    end

  fifo_bound: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_count_i <= FIFO_DEPTH)
    else
    begin
      $error("prefetch FIFO holds more than its depth");
      assert_errs++;
    end

endmodule

bind if_stage if_stage_checker #(
  .FIFO_DEPTH (FIFO_DEPTH)
) if_stage_checker_inst (
  .clk            (clk),
  .rst_n          (rst_n),
  .ctrl_i         (ctrl_i),
  .instr_req_i    (instr_req_o),
  .instr_addr_i   (instr_addr_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_rvalid_i (instr_rvalid_i),
  .fifo_count_i   (prefetch_fifo_inst.count_q)
);

`default_nettype wire

/* verification/tb_if_stage.sv */
// Testbench for the instruction fetch stage
// Random-latency memory model, redirect commands from the data file, handoff checks

`timescale 1ns/1ps
`default_nettype none

module tb_if_stage;

  localparam int unsigned FIFO_DEPTH = 4;
  localparam int          MAX_TESTS  = 32;
  localparam logic [31:0] SEED       = 32'hf4c1630c;

  logic                   clk;
  logic                   rst_n;
  fetch_pkg::fetch_ctrl_t ctrl;
  fetch_pkg::addr_t       boot_addr;
  fetch_pkg::mtvec_t      mtvec;
  fetch_pkg::addr_t       jump_target;
  fetch_pkg::addr_t       branch_target;
  fetch_pkg::addr_t       mepc;
  logic                   instr_req;
  fetch_pkg::addr_t       instr_addr;
  logic                   instr_gnt;
  logic                   instr_rvalid;
  fetch_pkg::instr_t      instr_rdata;
  logic                   instr_err;
  logic                   id_ready;
  fetch_pkg::if_id_pipe_t pipe;
  logic                   busy;

  // Six words per line: pc_mux, data, irq_id, flags, count, first PC
  logic [31:0]      tdata [0:6*MAX_TESTS-1];
  int unsigned      errors;
  int unsigned      wd_limit;
  logic [31:0]      mem_lfsr;
  logic [31:0]      stim_lfsr;
  int unsigned      mem_cyc;
  int unsigned      gnt_wait;
  fetch_pkg::addr_t pend_addr [$];
  int unsigned      pend_due [$];
  int               inflight;
  string            test_name;

  if_stage #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) if_stage_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_i          (ctrl),
    .boot_addr_i     (boot_addr),
    .mtvec_i         (mtvec),
    .jump_target_i   (jump_target),
    .branch_target_i (branch_target),
    .mepc_i          (mepc),
    .instr_req_o     (instr_req),
    .instr_addr_o    (instr_addr),
    .instr_gnt_i     (instr_gnt),
    .instr_rvalid_i  (instr_rvalid),
    .instr_rdata_i   (instr_rdata),
    .instr_err_i     (instr_err),
    .id_ready_i      (id_ready),
    .if_id_pipe_o    (pipe),
    .if_busy_o       (busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  task automatic draw_bits(ref logic [31:0] state, input int n, output logic [3:0] bits);
    bits = '0;
    for (int k = 0; k < n; k++)
    begin
      state = lfsr_next(state);
      bits  = {bits[2:0], state[0]};
    end
  endtask

  // Bus error window of the memory map
  function automatic logic in_err_range(input logic [31:0] a);
    return (a >= 32'h0000_F000) && (a <= 32'h0000_F0FF);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Instruction memory model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    logic [3:0] r;
    if (!rst_n)
    begin
      gnt_wait = 0;
      pend_addr.delete();
      pend_due.delete();
      instr_gnt    <= 1'b0;
      instr_rvalid <= 1'b0;
    end
    else
    begin
      mem_cyc = mem_cyc + 1;
      if (instr_req && instr_gnt)
      begin
        // Response delay of 0 to 3 cycles after the grant cycle
        draw_bits(mem_lfsr, 2, r);
        pend_addr.push_back(instr_addr);
        pend_due.push_back(mem_cyc + r);
        // Next grant delay
        draw_bits(mem_lfsr, 2, r);
        gnt_wait = r;
      end
      else if (instr_req && (gnt_wait != 0))
      begin
        gnt_wait = gnt_wait - 1;
      end
      instr_gnt <= (gnt_wait == 0);
      // In order, at most one response per cycle
      if ((pend_addr.size() != 0) && (pend_due[0] <= mem_cyc))
      begin
        instr_rvalid <= 1'b1;
        instr_rdata  <= ~pend_addr[0];
        instr_err    <= in_err_range(pend_addr[0]);
        pend_addr.pop_front();
        pend_due.pop_front();
      end
      else
      begin
        instr_rvalid <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Busy flag and reset state
  //////////////////////////////////////////////////////////////////////

  // Own count of granted requests still waiting for rvalid
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      inflight = 0;
      if (busy !== 1'b0)
      begin
        $display("Error: reset busy expected 0 actual %b", busy);
        errors++;
      end
      if (pipe.instr_valid !== 1'b0)
      begin
        $display("Error: reset instr_valid expected 0 actual %b", pipe.instr_valid);
        errors++;
      end
    end
    else
    begin
      // Anything in flight keeps the stage busy
      if ((inflight != 0) && (busy !== 1'b1))
      begin
        $display("Error: %s busy expected 1 actual %b", test_name, busy);
        errors++;
      end
      inflight = inflight + int'(instr_req && instr_gnt) - int'(instr_rvalid);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // One redirect command and its handoffs
  //////////////////////////////////////////////////////////////////////

  task automatic run_test(input int idx);
    fetch_pkg::pc_mux_e mux;
    logic [31:0]        data;
    logic [31:0]        exp_pc;
    logic [4:0]         irq;
    logic [3:0]         flags;
    logic [3:0]         r;
    int unsigned        count;
    int unsigned        got;
    int unsigned        cyc;
    logic               valid_prev;
    logic               halt_prev;
    string              name;
    mux       = fetch_pkg::pc_mux_e'(tdata[6*idx][2:0]);
    data      = tdata[6*idx+1];
    irq       = tdata[6*idx+2][4:0];
    flags     = tdata[6*idx+3][3:0];
    count     = tdata[6*idx+4];
    exp_pc    = tdata[6*idx+5];
    name      = $sformatf("t%0d_%s", idx, mux.name());
    test_name = name;

    @(posedge clk);
    ctrl.pc_set   <= 1'b1;
    ctrl.pc_mux   <= mux;
    ctrl.halt_if  <= 1'b0;
    // Unselected sources carry the inverse, a wrong pick gives a wrong first PC
    boot_addr     <= ~data;
    jump_target   <= ~data;
    branch_target <= ~data;
    mepc          <= ~data;
    mtvec         <= ~data[31:8];
    ctrl.irq_id   <= ~irq;
    case (mux)
      fetch_pkg::PC_BOOT:      boot_addr     <= data;
      fetch_pkg::PC_JUMP:      jump_target   <= data;
      fetch_pkg::PC_BRANCH:    branch_target <= data;
      fetch_pkg::PC_MRET:      mepc          <= data;
      fetch_pkg::PC_EXCEPTION: mtvec         <= data[31:8];
      fetch_pkg::PC_IRQ:
      begin
        mtvec       <= data[31:8];
        ctrl.irq_id <= irq;
      end
      default: ;
    endcase
    id_ready      <= 1'b1;
    // Redirect taken here, samples still show the old stream
    @(posedge clk);
    ctrl.pc_set <= 1'b0;

    got        = 0;
    cyc        = 0;
    valid_prev = 1'b0;
    halt_prev  = 1'b0;
    while (got < count)
    begin
      @(posedge clk);
      cyc = cyc + 1;
      // Halt seen by the stage on the last edge
      if (halt_prev && pipe.instr_valid && !valid_prev)
      begin
        $display("%s: instr_valid rose while fetch was halted", name);
        errors++;
      end
      if (pipe.instr_valid && id_ready)
      begin
        if (pipe.pc !== exp_pc)
        begin
          $display("Error: %s pc expected %h actual %h", name, exp_pc, pipe.pc);
          errors++;
        end
        if (pipe.instr !== ~exp_pc)
        begin
          $display("Error: %s instr expected %h actual %h", name, ~exp_pc, pipe.instr);
          errors++;
        end
        if (pipe.bus_err !== in_err_range(exp_pc))
        begin
          $display("Error: %s bus_err expected %b actual %b", name,
                   in_err_range(exp_pc), pipe.bus_err);
          errors++;
        end
        exp_pc = exp_pc + 32'd4;
        got    = got + 1;
      end
      valid_prev = pipe.instr_valid;
      halt_prev  = ctrl.halt_if;
      // Back-pressure from decode
      if (flags[0])
      begin
        draw_bits(stim_lfsr, 1, r);
        id_ready <= r[0];
      end
      else
      begin
        id_ready <= 1'b1;
      end
      ctrl.halt_if <= flags[1] && (cyc >= 4) && (cyc < 14);
    end
  endtask

  // Watchdog
  initial
  begin
    wait (wd_limit != 0);
    repeat (wd_limit) @(posedge clk);
    $display("Timeout: handoffs stopped arriving within %0d cycles", wd_limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    int          n_tests;
    int unsigned total;
    int unsigned assert_errs;
    rst_n         = 1'b0;
    ctrl          = '0;
    boot_addr     = '0;
    mtvec         = '0;
    jump_target   = '0;
    branch_target = '0;
    mepc          = '0;
    id_ready      = 1'b1;
    instr_gnt     = 1'b0;
    instr_rvalid  = 1'b0;
    instr_rdata   = '0;
    instr_err     = 1'b0;
    errors        = 0;
    mem_cyc       = 0;
    gnt_wait      = 0;
    inflight      = 0;
    test_name     = "reset";
    mem_lfsr      = SEED;
    stim_lfsr     = SEED;

    // A zero count ends the list
    for (int i = 0; i < 6*MAX_TESTS; i++)
      tdata[i] = '0;
    $readmemh("verification/if_stage_testdata.txt", tdata);
    n_tests = 0;
    total   = 0;
    while ((n_tests < MAX_TESTS) && (tdata[6*n_tests+4] != 0))
    begin
      total   = total + tdata[6*n_tests+4];
      n_tests = n_tests + 1;
    end
    wd_limit = total * 40 + 200;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    if (n_tests == 0)
    begin
      $display("No test lines were read from the data file");
      errors++;
    end
    for (int i = 0; i < n_tests; i++)
      run_test(i);
    repeat (4) @(posedge clk);

    assert_errs = if_stage_inst.if_stage_checker_inst.assert_errs;
    $display("Errors: %0d check, %0d assertion", errors, assert_errs);
    if ((errors == 0) && (assert_errs == 0))
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/if_stage_testdata.txt */
// Columns in hex: pc_mux data irq_id flags count first_pc
// pc_mux 0 boot 1 jump 2 branch 3 exception 4 irq 5 mret; flags bit0 random id_ready, bit1 halt
0 00001003 00 0 0C 00001000
1 00002001 00 0 08 00002000
2 00003105 00 1 14 00003104
3 000080AC 00 0 06 00008000
4 00008000 0B 2 0C 0000802C
5 0000F0F1 00 0 0A 0000F0F0
0 0000F000 00 3 10 0000F000
1 00004001 00 2 0C 00004000
2 00005001 00 0 03 00005000
3 0000F0FF 00 1 06 0000F000
4 00006000 1F 0 06 0000607C
0 00000000 00 1 05 00000000
5 00007FFD 00 0 04 00007FFC

/* filelist.f */
hw/fetch_pkg.sv
hw/fetch_addr_gen.sv
hw/prefetch_fifo.sv
hw/if_id_stage.sv
hw/if_stage.sv
verification/if_stage_checker.sv
verification/tb_if_stage.sv

/* Bender.yml */
package:
  name: if_stage

sources:
  # RTL, package first
  - files:
      - hw/fetch_pkg.sv
      - hw/fetch_addr_gen.sv
      - hw/prefetch_fifo.sv
      - hw/if_id_stage.sv
      - hw/if_stage.sv

  # Verification
  - target: test
    files:
      - verification/if_stage_checker.sv
      - verification/tb_if_stage.sv
